// File: key_unlock.f
+incdir+source
source/key_unlock_pkg.sv
source/modexp_if.sv
source/passphrase_checker.sv
source/mod_exp_unit.sv
source/unlock_sequencer.sv
source/key_unlock.sv
testbench/tb_key_unlock.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the key_unlock testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_key_unlock \
	-f key_unlock.f

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/Vtb_key_unlock

// File: testbench/tb_key_unlock_input.txt
# P word | K byte done clear | C cipher plain | L led_pass led_fail | W cycles | E end
# words and bytes in hex, the rest decimal; plain = cipher^7 mod 0xca1
P 00000007
P 00000ca1
P 4b70db7f
# first word goes in while still locked and must be held
C 00000002 00000080
W 500
L 0 0
# wrong phrase 1c 32
K 1c 0 0
K 32 0 0
K 5a 1 0
L 0 1
# partial phrase cleared, then the right one 1c 32 21
K 1c 0 0
K 00 0 1
K 1c 0 0
K 32 0 0
K 21 0 0
K 5a 1 0
L 1 0
C 00000003 0000088b
C 0000000a 0000014b
# wrong try after unlock keeps pass lit
K 21 0 0
K 5a 1 0
L 1 1
C 00000064 00000b38
C 000004d2 00000734
K 1c 0 0
K 32 0 0
K 21 0 0
K 5a 1 0
L 1 0
C 00000ca0 00000ca0
C 00000001 00000001
C 00000000 00000000
E

// File: testbench/tb_key_unlock.sv
`timescale 1ns/1ps
`include "key_unlock_settings.svh"

module tb_key_unlock;

	localparam int READY_LIMIT = 4000; // cycles allowed for any ready to rise
	localparam int DRAIN_LIMIT = 4000;

	logic clk = 1'b0;
	logic rst;
	key_unlock_pkg::key_word_t rsa_data_i, aes_data_i, out_data_o;
	key_unlock_pkg::key_byte_t ps2_data_i;
	logic rsa_valid_i, aes_valid_i, ps2_valid_i, ps2_done_i, ps2_reset_i;
	logic stall_i, out_ready_i;
	logic rsa_ready_o, aes_ready_o, out_valid_o, led_pass_o, led_fail_o;

	key_unlock_pkg::key_word_t expect_q[$]; // owed plaintexts with the oldest in front
	integer seed = 32'hedd6f516;
	int fd;
	logic prev_hold = 1'b0; // valid without ready at last sample
	key_unlock_pkg::key_word_t prev_data;

	always #10 clk = ~clk;

	key_unlock i_key_unlock (.*);

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "testbench stopped at first error");
	endtask

	task automatic fail_with(input string why);
		$display("ERROR at %0t: %s", $time, why);
		abort_run();
	endtask

	task automatic check_word(input string name, input key_unlock_pkg::key_word_t exp_w,
		input key_unlock_pkg::key_word_t got_w);
		if (got_w !== exp_w) begin
			$display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp_w, got_w);
			abort_run();
		end
	endtask

	task automatic check_led(input string name, input logic exp_b, input logic got_b);
		if (got_b !== exp_b) begin
			$display("MISMATCH at %0t: %s expected %b got %b", $time, name, exp_b, got_b);
			abort_run();
		end
	endtask

	// inputs change 2 ns after the edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic send_param(input key_unlock_pkg::key_word_t word);
		int n = 0;
		while (rsa_ready_o !== 1'b1 && n < READY_LIMIT) begin
			next_cycle();
			n++;
		end
		if (rsa_ready_o !== 1'b1)
			fail_with("rsa_ready_o never rose for a parameter word");
		rsa_data_i = word;
		rsa_valid_i = 1'b1;
		next_cycle();
		rsa_valid_i = 1'b0;
	endtask

	task automatic send_key(input key_unlock_pkg::key_byte_t kb, input logic done,
		input logic clear);
		ps2_data_i = kb;
		ps2_done_i = done;
		ps2_reset_i = clear;
		ps2_valid_i = 1'b1;
		next_cycle();
		ps2_valid_i = 1'b0;
		ps2_done_i = 1'b0;
		ps2_reset_i = 1'b0;
		if (done) begin
			next_cycle(); // check pulse two cycles after enter
			next_cycle(); // leds one cycle later and the checker collecting again
		end
	endtask

	task automatic send_cipher(input key_unlock_pkg::key_word_t cw,
		input key_unlock_pkg::key_word_t pw);
		int n = 0;
		while (aes_ready_o !== 1'b1 && n < READY_LIMIT) begin
			next_cycle();
			n++;
		end
		if (aes_ready_o !== 1'b1)
			fail_with("aes_ready_o never rose for the next ciphertext word");
		expect_q.push_back(pw);
		aes_data_i = cw;
		aes_valid_i = 1'b1;
		next_cycle();
		aes_valid_i = 1'b0;
		check_led("aes_ready_o", 1'b0, aes_ready_o); // slot now taken
	endtask

	task automatic skip_comment();
		int ch = 0;
		while (ch != 10 && ch >= 0)
			ch = $fgetc(fd);
	endtask

	task automatic drain_outputs();
		int n = 0;
		while (expect_q.size() != 0 && n < DRAIN_LIMIT) begin
			next_cycle();
			n++;
		end
	endtask

	// random back-pressure and stall pulses
	initial begin
		logic [31:0] rnd;
		out_ready_i = 1'b0;
		stall_i = 1'b0;
		forever begin
			next_cycle();
			rnd = $random(seed);
			out_ready_i = (rnd[1:0] != 2'b00); // ready about 3 cycles in 4
			stall_i = (rnd[6:4] == 3'b000);
		end
	end

	// output port sampled mid-cycle where everything has settled
	always @(negedge clk) begin
		if (!rst) begin
			if (prev_hold) begin
				check_led("out_valid_o", 1'b1, out_valid_o); // no drop under back-pressure
				check_word("out_data_o", prev_data, out_data_o);
			end
			if (out_valid_o && !led_pass_o)
				fail_with("out_valid_o high while the passphrase is not accepted");
			if (out_valid_o && out_ready_i) begin
				if (expect_q.size() == 0)
					fail_with("output word arrived with none expected");
				else
					check_word("out_data_o", expect_q.pop_front(), out_data_o);
			end
			prev_hold = out_valid_o && !out_ready_i;
			prev_data = out_data_o;
		end
	end

	initial begin
		int ch;
		int got;
		int n_param;
		int kdone;
		int kclear;
		int n_idle;
		int led_p;
		int led_f;
		logic finished;
		logic [7:0] cb;
		key_unlock_pkg::key_word_t w0;
		key_unlock_pkg::key_word_t w1;
		key_unlock_pkg::key_byte_t kb;
		rst = 1'b1;
		rsa_data_i = '0;
		rsa_valid_i = 1'b0;
		aes_data_i = '0;
		aes_valid_i = 1'b0;
		ps2_data_i = '0;
		ps2_valid_i = 1'b0;
		ps2_done_i = 1'b0;
		ps2_reset_i = 1'b0;
		n_param = 0;
		finished = 1'b0;
		fd = $fopen("testbench/tb_key_unlock_input.txt", "r");
		if (fd == 0)
			fail_with("cannot open testbench/tb_key_unlock_input.txt");
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		check_led("rsa_ready_o", 1'b1, rsa_ready_o); // only the parameter port is open
		check_led("aes_ready_o", 1'b0, aes_ready_o);
		check_led("out_valid_o", 1'b0, out_valid_o);
		check_led("led_pass_o", 1'b0, led_pass_o);
		check_led("led_fail_o", 1'b0, led_fail_o);
		while (!finished) begin
			ch = $fgetc(fd);
			if (ch < 0)
				fail_with("stimulus file ended without an E command");
			cb = 8'(ch);
			case (cb)
				"#": skip_comment();
				"P": begin
					got = $fscanf(fd, "%h", w0);
					if (got != 1)
						fail_with("malformed P line in stimulus file");
					send_param(w0);
					n_param++;
					if (n_param == `PARAM_WORDS) begin
						check_led("rsa_ready_o", 1'b0, rsa_ready_o); // block complete
						check_led("aes_ready_o", 1'b1, aes_ready_o);
					end
				end
				"K": begin
					got = $fscanf(fd, "%h %d %d", kb, kdone, kclear);
					if (got != 3)
						fail_with("malformed K line in stimulus file");
					send_key(kb, kdone != 0, kclear != 0);
				end
				"C": begin
					got = $fscanf(fd, "%h %h", w0, w1);
					if (got != 2)
						fail_with("malformed C line in stimulus file");
					send_cipher(w0, w1);
				end
				"L": begin
					got = $fscanf(fd, "%d %d", led_p, led_f);
					if (got != 2)
						fail_with("malformed L line in stimulus file");
					check_led("led_pass_o", led_p != 0, led_pass_o);
					check_led("led_fail_o", led_f != 0, led_fail_o);
				end
				"W": begin
					got = $fscanf(fd, "%d", n_idle);
					if (got != 1)
						fail_with("malformed W line in stimulus file");
					repeat (n_idle) next_cycle();
				end
				"E": finished = 1'b1;
				8'd9, 8'd10, 8'd13, 8'd32: begin
				end
				default: fail_with("unknown command in stimulus file");
			endcase
		end
		$fclose(fd);
		drain_outputs(); // every queued plaintext must have left
		if (expect_q.size() != 0) begin
			fail_with("expected plaintext words never came out");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

// File: source/key_unlock.sv
`timescale 1ns/1ps

module key_unlock (
	input logic clk,
	input logic rst,
	input key_unlock_pkg::key_word_t rsa_data_i,
	input logic rsa_valid_i,
	output logic rsa_ready_o,
	input key_unlock_pkg::key_word_t aes_data_i,
	input logic aes_valid_i,
	output logic aes_ready_o,
	input key_unlock_pkg::key_byte_t ps2_data_i,
	input logic ps2_valid_i,
	input logic ps2_done_i,
	input logic ps2_reset_i,
	input logic stall_i, // freezes the exponent unit
	output key_unlock_pkg::key_word_t out_data_o,
	output logic out_valid_o,
	input logic out_ready_i,
	output logic led_pass_o,
	output logic led_fail_o
);

	key_unlock_pkg::key_word_t digest_ref; // stored digest, sequencer to checker
	logic check_pass;
	logic check_fail;

	modexp_if job_if ();

	passphrase_checker i_passphrase_checker (
		.clk (clk),
		.rst (rst),
		.ps2_data_i (ps2_data_i),
		.ps2_valid_i (ps2_valid_i),
		.ps2_done_i (ps2_done_i),
		.ps2_reset_i (ps2_reset_i),
		.digest_ref_i (digest_ref),
		.check_pass_o (check_pass),
		.check_fail_o (check_fail)
	);

	mod_exp_unit i_mod_exp_unit (
		.clk (clk),
		.rst (rst),
		.stall_i (stall_i),
		.job (job_if.unit)
	);

	unlock_sequencer i_unlock_sequencer (
		.clk (clk),
		.rst (rst),
		.rsa_data_i (rsa_data_i),
		.rsa_valid_i (rsa_valid_i),
		.rsa_ready_o (rsa_ready_o),
		.aes_data_i (aes_data_i),
		.aes_valid_i (aes_valid_i),
		.aes_ready_o (aes_ready_o),
		.out_data_o (out_data_o),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.check_pass_i (check_pass),
		.check_fail_i (check_fail),
		.digest_ref_o (digest_ref),
		.led_pass_o (led_pass_o),
		.led_fail_o (led_fail_o),
		.job (job_if.seq)
	);

endmodule

// File: source/unlock_sequencer.sv
`timescale 1ns/1ps
`include "key_unlock_settings.svh"

module unlock_sequencer (
	input logic clk,
	input logic rst,
	input key_unlock_pkg::key_word_t rsa_data_i,
	input logic rsa_valid_i,
	output logic rsa_ready_o,
	input key_unlock_pkg::key_word_t aes_data_i,
	input logic aes_valid_i,
	output logic aes_ready_o,
	output key_unlock_pkg::key_word_t out_data_o,
	output logic out_valid_o,
	input logic out_ready_i,
	input logic check_pass_i,
	input logic check_fail_i,
	output key_unlock_pkg::key_word_t digest_ref_o,
	output logic led_pass_o,
	output logic led_fail_o,
	modexp_if.seq job
);

	key_unlock_pkg::seq_state_e state;
	logic [`PARAM_CNT_W-1:0] param_cnt; // which parameter word comes next
	key_unlock_pkg::key_word_t exp_q;
	key_unlock_pkg::key_word_t mod_q;
	key_unlock_pkg::key_word_t digest_q;
	key_unlock_pkg::key_word_t cipher_q; // base, stable through the job
	key_unlock_pkg::key_word_t result_q; // one-word hold register
	logic rsa_fire;
	logic aes_fire;
	logic out_fire;

	assign rsa_ready_o = (state == key_unlock_pkg::LOAD_PARAMS);
	assign aes_ready_o = (state == key_unlock_pkg::RUN); // unit idle, slot empty
	assign rsa_fire = rsa_valid_i && rsa_ready_o;
	assign aes_fire = aes_valid_i && aes_ready_o;

	// held word goes out only once the phrase matched
	assign out_valid_o = (state == key_unlock_pkg::SLOT_HOLD) && led_pass_o;
	assign out_data_o = result_q;
	assign out_fire = out_valid_o && out_ready_i;

	assign job.start = (state == key_unlock_pkg::SLOT_START);
	assign job.base = cipher_q;
	assign job.exponent = exp_q;
	assign job.modulus = mod_q;

	assign digest_ref_o = digest_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= key_unlock_pkg::LOAD_PARAMS;
			param_cnt <= '0;
		end else begin
			case (state)
				key_unlock_pkg::LOAD_PARAMS: begin
					if (rsa_fire) begin
						param_cnt <= param_cnt + 1'b1;
						if (param_cnt == `PARAM_CNT_W'(`PARAM_WORDS - 1))
							state <= key_unlock_pkg::RUN;
					end
				end
				key_unlock_pkg::RUN: begin
					if (aes_fire)
						state <= key_unlock_pkg::SLOT_START;
				end
				key_unlock_pkg::SLOT_START: begin
					state <= key_unlock_pkg::SLOT_BUSY; // unit busy from here
				end
				key_unlock_pkg::SLOT_BUSY: begin
					if (job.done)
						state <= key_unlock_pkg::SLOT_HOLD;
				end
				key_unlock_pkg::SLOT_HOLD: begin
					if (out_fire)
						state <= key_unlock_pkg::RUN;
				end
				default: begin
					state <= key_unlock_pkg::LOAD_PARAMS;
				end
			endcase
		end
	end

	// pass latches until reset, fail drops on a later pass
	always_ff @(posedge clk) begin
		if (rst) begin
			led_pass_o <= 1'b0;
			led_fail_o <= 1'b0;
		end else begin
			if (check_pass_i) begin
				led_pass_o <= 1'b1;
				led_fail_o <= 1'b0;
			end else if (check_fail_i) begin
				led_fail_o <= 1'b1;
			end
		end
	end

	// parameter block, in order exponent, modulus, digest
	always_ff @(posedge clk) begin
		if (rsa_fire) begin
			case (param_cnt)
				`PARAM_CNT_W'(0): exp_q <= rsa_data_i;
				`PARAM_CNT_W'(1): mod_q <= rsa_data_i;
				default: digest_q <= rsa_data_i;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (aes_fire)
			cipher_q <= aes_data_i;
		if (state == key_unlock_pkg::SLOT_BUSY && job.done)
			result_q <= job.result; // capture with the done pulse
	end

endmodule

// File: source/mod_exp_unit.sv
`timescale 1ns/1ps
`include "key_unlock_settings.svh"

// right-to-left square and multiply giving base^exponent mod modulus
module mod_exp_unit (
	input logic clk,
	input logic rst,
	input logic stall_i,
	modexp_if.unit job
);

	key_unlock_pkg::exp_state_e state;
	key_unlock_pkg::key_word_t b_q; // running base power
	key_unlock_pkg::key_word_t e_q; // remaining exponent bits
	key_unlock_pkg::key_word_t m_q;
	key_unlock_pkg::key_word_t r_q; // running result
	logic [`KEY_CNT_W-1:0] mul_cnt; // multiplier bit index from the msb
	logic [`KEY_W:0] acc; // one spare bit for the doubling

	key_unlock_pkg::key_word_t mul_a; // scanned operand
	key_unlock_pkg::key_word_t mul_b; // added operand below the modulus
	logic mul_bit;
	logic [`KEY_W:0] dbl, red1, sum, red2;
	logic mul_last;
	key_unlock_pkg::key_word_t e_shift;

	// squaring takes b*b and multiplying takes r*b
	assign mul_a = (state == key_unlock_pkg::MULTIPLY) ? r_q : b_q;
	assign mul_b = b_q;
	assign mul_bit = mul_a[`KEY_CNT_W'(`KEY_W - 1) - mul_cnt];

	// interleaved step acc = 2*acc + bit*b kept below m
	assign dbl = {acc[`KEY_W-1:0], 1'b0};
	assign red1 = (dbl >= {1'b0, m_q}) ? dbl - {1'b0, m_q} : dbl;
	assign sum = red1 + (mul_bit ? {1'b0, mul_b} : '0);
	assign red2 = (sum >= {1'b0, m_q}) ? sum - {1'b0, m_q} : sum;

	assign mul_last = (mul_cnt == `KEY_CNT_W'(`KEY_W - 1));
	assign e_shift = e_q >> 1;

	assign job.done = (state == key_unlock_pkg::DONE);
	assign job.result = r_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= key_unlock_pkg::IDLE;
			mul_cnt <= '0;
			acc <= '0;
		end else begin
			case (state)
				key_unlock_pkg::IDLE: begin
					if (job.start) begin
						mul_cnt <= '0;
						acc <= '0;
						if (job.exponent == '0)
							state <= key_unlock_pkg::DONE; // x^0 = 1
						else if (job.exponent[0])
							state <= key_unlock_pkg::MULTIPLY;
						else
							state <= key_unlock_pkg::SQUARE;
					end
				end
				key_unlock_pkg::MULTIPLY,
				key_unlock_pkg::SQUARE: begin
					if (!stall_i) begin
						if (mul_last) begin
							acc <= '0;
							mul_cnt <= '0;
							if (state == key_unlock_pkg::MULTIPLY)
								state <= key_unlock_pkg::SQUARE;
							else if (e_shift == '0)
								state <= key_unlock_pkg::DONE; // no set bits left
							else if (e_shift[0])
								state <= key_unlock_pkg::MULTIPLY;
						end else begin
							acc <= red2;
							mul_cnt <= mul_cnt + 1'b1;
						end
					end
				end
				key_unlock_pkg::DONE: begin
					state <= key_unlock_pkg::IDLE; // done lasts one cycle
				end
				default: begin
					state <= key_unlock_pkg::IDLE;
				end
			endcase
		end
	end

	// operand registers
	always_ff @(posedge clk) begin
		if (state == key_unlock_pkg::IDLE && job.start) begin
			b_q <= job.base; // RSA ciphertext is below the modulus
			e_q <= job.exponent;
			m_q <= job.modulus;
			r_q <= key_unlock_pkg::key_word_t'(1);
		end else if (!stall_i && mul_last) begin
			if (state == key_unlock_pkg::MULTIPLY) begin
				r_q <= red2[`KEY_W-1:0];
			end else if (state == key_unlock_pkg::SQUARE) begin
				b_q <= red2[`KEY_W-1:0];
				e_q <= e_shift; // next exponent bit
			end
		end
	end

endmodule

// File: source/passphrase_checker.sv
`timescale 1ns/1ps
`include "key_unlock_settings.svh"

module passphrase_checker (
	input logic clk,
	input logic rst,
	input key_unlock_pkg::key_byte_t ps2_data_i,
	input logic ps2_valid_i,
	input logic ps2_done_i,
	input logic ps2_reset_i,
	input key_unlock_pkg::key_word_t digest_ref_i,
	output logic check_pass_o,
	output logic check_fail_o
);

	key_unlock_pkg::pass_state_e state;
	logic [`PASS_CNT_W-1:0] key_cnt; // bytes folded so far
	key_unlock_pkg::key_word_t digest;
	key_unlock_pkg::key_word_t digest_rot;
	key_unlock_pkg::key_word_t digest_next;
	logic key_stroke; // plain byte, not enter or clear
	logic buf_full;

	// rotate left by 5, xor in the byte
	assign digest_rot = {digest[`KEY_W-6:0], digest[`KEY_W-1:`KEY_W-5]};
	assign digest_next = digest_rot ^ key_unlock_pkg::key_word_t'(ps2_data_i);

	assign key_stroke = ps2_valid_i && !ps2_done_i && !ps2_reset_i;
	assign buf_full = (key_cnt == `PASS_CNT_W'(`PASS_MAX - 1)); // this byte is the last

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= key_unlock_pkg::COLLECT;
			key_cnt <= '0;
			digest <= `DIGEST_SEED;
			check_pass_o <= 1'b0;
			check_fail_o <= 1'b0;
		end else begin
			check_pass_o <= 1'b0; // pulses by default
			check_fail_o <= 1'b0;
			case (state)
				key_unlock_pkg::COLLECT: begin
					if (ps2_valid_i && ps2_reset_i) begin
						key_cnt <= '0; // clear wins over enter
						digest <= `DIGEST_SEED;
					end else if (ps2_valid_i && ps2_done_i) begin
						state <= key_unlock_pkg::CHECK; // enter key, not folded
					end else if (key_stroke) begin
						digest <= digest_next;
						key_cnt <= key_cnt + 1'b1;
						if (buf_full)
							state <= key_unlock_pkg::CHECK; // full buffer acts like enter
					end
				end
				key_unlock_pkg::CHECK: begin
					// compare against stored digest from sequencer
					if (digest == digest_ref_i)
						check_pass_o <= 1'b1;
					else
						check_fail_o <= 1'b1;
					state <= key_unlock_pkg::HOLD;
				end
				key_unlock_pkg::HOLD: begin
					// pulse out now, then a fresh try
					state <= key_unlock_pkg::COLLECT;
					key_cnt <= '0;
					digest <= `DIGEST_SEED;
				end
				default: begin
					state <= key_unlock_pkg::COLLECT;
				end
			endcase
		end
	end

endmodule

// File: source/modexp_if.sv
`timescale 1ns/1ps

// one exponentiation job, sequencer to exponent unit and back
interface modexp_if;

	logic start; // pulse, only while unit idle
	key_unlock_pkg::key_word_t base;
	key_unlock_pkg::key_word_t exponent;
	key_unlock_pkg::key_word_t modulus;
	key_unlock_pkg::key_word_t result; // valid with done
	logic done; // one-cycle pulse

	modport seq (
		output start, base, exponent, modulus,
		input result, done
	);

	modport unit (
		input start, base, exponent, modulus,
		output result, done
	);

endinterface

// File: source/key_unlock_pkg.sv
`include "key_unlock_settings.svh"

package key_unlock_pkg;

	typedef logic [`KEY_W-1:0] key_word_t; // data, exponent, modulus, digest
	typedef logic [7:0] key_byte_t; // ps2 scan byte

	// sequencer: parameter load, then one ciphertext slot
	typedef enum logic [2:0] {
		LOAD_PARAMS, // taking exponent, modulus, digest
		RUN, // slot empty, ciphertext accepted here
		SLOT_START, // start pulse to exponent unit
		SLOT_BUSY, // waiting for done
		SLOT_HOLD // result held until unlocked and taken
	} seq_state_e;

	typedef enum logic [1:0] {
		IDLE,
		SQUARE,
		MULTIPLY,
		DONE
	} exp_state_e;

	typedef enum logic [1:0] {
		COLLECT,
		CHECK,
		HOLD
	} pass_state_e;

endpackage

// File: source/key_unlock_settings.svh
`ifndef KEY_UNLOCK_SETTINGS_SVH
`define KEY_UNLOCK_SETTINGS_SVH

// word width of exponent, modulus, data and digest
`define KEY_W 32
`define KEY_CNT_W 5 // counts one multiply, 0..KEY_W-1

// keyboard side
`define PASS_MAX 16
`define PASS_CNT_W 5

// parameter block: exponent, modulus, digest
`define PARAM_WORDS 3
`define PARAM_CNT_W 2

`define DIGEST_SEED 32'h5a3c_96e1 // digest start value

`endif
